// File: Bender.yml
package:
  name: rv_soc

sources:
  - design/rv_pkg.sv
  - design/wb_if.sv
  - design/rv_program_counter.sv
  - design/rv_regfile.sv
  - design/rv_imm_decode.sv
  - design/rv_alu.sv
  - design/rv_core.sv
  - design/wb_ram.sv
  - design/rv_soc.sv
  - target: simulation
    files:
      - dv/rv_core_assertions.sv
      - dv/rv_soc_tb.sv

// File: design/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
    input  rv_pkg::instr_u          instr_i,
    input  logic [rv_pkg::XLEN-1:0] op_a_i,
    input  logic [rv_pkg::XLEN-1:0] op_b_i,
    input  logic [rv_pkg::XLEN-1:0] pc_i,
    input  logic [rv_pkg::XLEN-1:0] imm_i,
    output logic [rv_pkg::XLEN-1:0] result_o,
    output logic [rv_pkg::XLEN-1:0] target_o,
    output logic                    take_branch_o
);

    rv_pkg::opcode_e         opcode;
    logic                    alt;
    logic [rv_pkg::XLEN-1:0] b;
    logic [4:0]              shamt;
    logic [rv_pkg::XLEN-1:0] arith;
    logic [rv_pkg::XLEN-1:0] addr_sum;
    logic [rv_pkg::XLEN-1:0] pc_sum;
    logic                    lt;
    logic                    ltu;
    logic                    cond;

    assign opcode = instr_i.r_fmt.opcode;
    assign alt = (instr_i.r_fmt.funct7 == rv_pkg::F7_ALT);
    assign b = (opcode == rv_pkg::OPC_OP) ? op_b_i : imm_i;
    assign shamt = b[4:0];
    assign addr_sum = op_a_i + imm_i;
    assign pc_sum = pc_i + imm_i;
    assign lt = $signed(op_a_i) < $signed(op_b_i);
    assign ltu = op_a_i < op_b_i;

    always_comb begin
        case (instr_i.r_fmt.funct3)
            rv_pkg::F3_ADD: arith = (opcode == rv_pkg::OPC_OP && alt) ? op_a_i - b : op_a_i + b;
            rv_pkg::F3_SLL: arith = op_a_i << shamt;
            rv_pkg::F3_SLT: arith = {{(rv_pkg::XLEN-1){1'b0}}, $signed(op_a_i) < $signed(b)};
            rv_pkg::F3_SLTU: arith = {{(rv_pkg::XLEN-1){1'b0}}, op_a_i < b};
            rv_pkg::F3_XOR: arith = op_a_i ^ b;
            rv_pkg::F3_SR: arith = alt ? $unsigned($signed(op_a_i) >>> shamt) : op_a_i >> shamt;
            rv_pkg::F3_OR: arith = op_a_i | b;
            default: arith = op_a_i & b;  // AND is the last funct3 code.
        endcase
    end

    always_comb begin
        case (opcode)
            rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM: result_o = arith;
            rv_pkg::OPC_LUI: result_o = imm_i;
            rv_pkg::OPC_AUIPC: result_o = pc_sum;
            rv_pkg::OPC_LOAD, rv_pkg::OPC_STORE: result_o = addr_sum;
            rv_pkg::OPC_JAL, rv_pkg::OPC_JALR: result_o = pc_i + rv_pkg::XLEN'(4);
            default: result_o = '0;
        endcase
    end

    assign target_o = (opcode == rv_pkg::OPC_JALR) ? {addr_sum[rv_pkg::XLEN-1:1], 1'b0} : pc_sum;

    always_comb begin
        case (instr_i.r_fmt.funct3)
            rv_pkg::F3_BEQ: cond = (op_a_i == op_b_i);
            rv_pkg::F3_BNE: cond = (op_a_i != op_b_i);
            rv_pkg::F3_BLT: cond = lt;
            rv_pkg::F3_BGE: cond = !lt;
            rv_pkg::F3_BLTU: cond = ltu;
            rv_pkg::F3_BGEU: cond = !ltu;
            default: cond = 1'b0;
        endcase
    end

    assign take_branch_o = (opcode == rv_pkg::OPC_BRANCH) && cond;

endmodule

// File: design/rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic                    clk_i,
    input  logic                    rst_i,
    wb_if.master                    bus,
    output logic                    retire_o,
    output logic                    retire_we_o,
    output logic [rv_pkg::XLEN-1:0] retire_pc_o,
    output logic [rv_pkg::XLEN-1:0] retire_data_o,
    output logic [4:0]              retire_rd_o
);

    rv_pkg::state_e          state;
    rv_pkg::instr_u          instr;
    rv_pkg::opcode_e         opcode;
    logic [2:0]              funct3;
    logic                    pc_count;
    logic                    pc_load;
    logic [rv_pkg::XLEN-1:0] pc;
    logic [rv_pkg::XLEN-1:0] rs1_data;
    logic [rv_pkg::XLEN-1:0] rs2_data;
    logic [rv_pkg::XLEN-1:0] wdata;
    logic                    reg_we;
    logic [rv_pkg::XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [rv_pkg::XLEN-1:0] imm_sel;
    logic [rv_pkg::XLEN-1:0] alu_out;
    logic [rv_pkg::XLEN-1:0] alu_out_r;
    logic [rv_pkg::XLEN-1:0] alu_out_rr;
    logic [rv_pkg::XLEN-1:0] target;
    logic                    take_branch;
    logic                    is_load, is_store, is_jump, writes_rd;
    logic [rv_pkg::XLEN-1:0] store_data;
    logic [3:0]              store_sel;
    logic [rv_pkg::XLEN-1:0] load_word;
    logic [rv_pkg::XLEN-1:0] load_data;
    logic [7:0]              load_byte;
    logic [15:0]             load_half;

    assign opcode = instr.r_fmt.opcode;
    assign funct3 = instr.r_fmt.funct3;
    assign is_load = (opcode == rv_pkg::OPC_LOAD);
    assign is_store = (opcode == rv_pkg::OPC_STORE);
    assign is_jump = (opcode == rv_pkg::OPC_JAL) || (opcode == rv_pkg::OPC_JALR);
    assign writes_rd = !is_store && (opcode != rv_pkg::OPC_BRANCH);

    rv_program_counter u_pc (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .count_i  (pc_count),
        .load_i   (pc_load),
        .value_i  (target),
        .pc_o     (pc),
        .pc_inc_o ()
    );

    rv_regfile u_regfile (
        .clk_i    (clk_i),
        .we_i     (reg_we),
        .waddr_i  (instr.r_fmt.rd),
        .raddr1_i (instr.r_fmt.rs1),
        .raddr2_i (instr.r_fmt.rs2),
        .wdata_i  (wdata),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    rv_imm_decode u_imm (
        .instr_i (instr),
        .imm_i_o (imm_i),
        .imm_s_o (imm_s),
        .imm_b_o (imm_b),
        .imm_u_o (imm_u),
        .imm_j_o (imm_j)
    );

    always_comb begin
        case (opcode)
            rv_pkg::OPC_STORE: imm_sel = imm_s;
            rv_pkg::OPC_BRANCH: imm_sel = imm_b;
            rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC: imm_sel = imm_u;
            rv_pkg::OPC_JAL: imm_sel = imm_j;
            default: imm_sel = imm_i;
        endcase
    end

    rv_alu u_alu (
        .instr_i       (instr),
        .op_a_i        (rs1_data),
        .op_b_i        (rs2_data),
        .pc_i          (pc),
        .imm_i         (imm_sel),
        .result_o      (alu_out),
        .target_o      (target),
        .take_branch_o (take_branch)
    );

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= rv_pkg::S_RESET;
        end else begin
            case (state)
                rv_pkg::S_FETCH: if (bus.ack) state <= rv_pkg::S_REG_READ;
                rv_pkg::S_REG_READ: state <= rv_pkg::S_EXECUTE;
                rv_pkg::S_EXECUTE: state <= rv_pkg::S_MEMORY;
                rv_pkg::S_MEMORY: begin
                    if (!(is_load || is_store) || bus.ack) begin
                        state <= rv_pkg::S_REG_WRITE;
                    end
                end
                default: state <= rv_pkg::S_FETCH;  // REG_WRITE and RESET.
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == rv_pkg::S_FETCH && bus.ack) instr <= bus.dat_r;
        if (state == rv_pkg::S_EXECUTE) alu_out_r <= alu_out;
        if (state == rv_pkg::S_MEMORY) alu_out_rr <= alu_out_r;
        if (state == rv_pkg::S_MEMORY && bus.ack) load_word <= bus.dat_r;
    end

    always_comb begin
        case (funct3)
            rv_pkg::F3_SB: begin
                store_data = {4{rs2_data[7:0]}};
                store_sel = 4'b0001 << alu_out_r[1:0];
            end
            rv_pkg::F3_SH: begin
                store_data = {2{rs2_data[15:0]}};
                store_sel = alu_out_r[1] ? 4'b1100 : 4'b0011;
            end
            rv_pkg::F3_SW: begin
                store_data = rs2_data;
                store_sel = 4'b1111;
            end
            default: begin
                store_data = rs2_data;
                store_sel = 4'b0000;  // Unknown width writes nothing.
            end
        endcase
    end

    assign load_byte = load_word[8*alu_out_rr[1:0] +: 8];
    assign load_half = load_word[16*alu_out_rr[1] +: 16];

    always_comb begin
        case (funct3)
            rv_pkg::F3_LB: load_data = {{24{load_byte[7]}}, load_byte};
            rv_pkg::F3_LBU: load_data = {24'h000000, load_byte};
            rv_pkg::F3_LH: load_data = {{16{load_half[15]}}, load_half};
            rv_pkg::F3_LHU: load_data = {16'h0000, load_half};
            rv_pkg::F3_LW: load_data = load_word;
            default: load_data = '0;
        endcase
    end

    always_comb begin
        bus.cyc = 1'b0;
        bus.stb = 1'b0;
        bus.we = 1'b0;
        bus.adr = pc;
        bus.sel = 4'b1111;
        bus.dat_w = store_data;
        pc_count = 1'b0;
        pc_load = 1'b0;
        case (state)
            rv_pkg::S_FETCH: begin
                bus.cyc = 1'b1;
                bus.stb = 1'b1;
            end
            rv_pkg::S_MEMORY: begin
                if (is_load || is_store) begin
                    bus.cyc = 1'b1;
                    bus.stb = 1'b1;
                    bus.we = is_store;
                    bus.adr = {alu_out_r[rv_pkg::XLEN-1:2], 2'b00};
                    bus.sel = is_store ? store_sel : 4'b1111;
                end
            end
            rv_pkg::S_REG_WRITE: begin
                pc_load = is_jump || take_branch;
                pc_count = !(is_jump || take_branch);
            end
            default: ;
        endcase
    end

    assign wdata = is_load ? load_data : alu_out_rr;
    assign reg_we = (state == rv_pkg::S_REG_WRITE) && writes_rd;

    assign retire_o = (state == rv_pkg::S_REG_WRITE);
    assign retire_we_o = reg_we;
    assign retire_pc_o = pc;  // PC still holds this instruction until the closing edge.
    assign retire_rd_o = instr.r_fmt.rd;
    assign retire_data_o = wdata;

endmodule

// File: design/rv_imm_decode.sv
`timescale 1ns/1ps

module rv_imm_decode (
    input  rv_pkg::instr_u          instr_i,
    output logic [rv_pkg::XLEN-1:0] imm_i_o,
    output logic [rv_pkg::XLEN-1:0] imm_s_o,
    output logic [rv_pkg::XLEN-1:0] imm_b_o,
    output logic [rv_pkg::XLEN-1:0] imm_u_o,
    output logic [rv_pkg::XLEN-1:0] imm_j_o
);

    logic sign;

    assign sign = instr_i.i_fmt.imm12[11];  // Bit 31 is the sign in every format.

    assign imm_i_o = {{20{sign}}, instr_i.i_fmt.imm12};

    assign imm_s_o = {{20{sign}}, instr_i.s_fmt.imm_hi, instr_i.s_fmt.imm_lo};

    assign imm_b_o = {{20{sign}}, instr_i.s_fmt.imm_lo[0], instr_i.s_fmt.imm_hi[5:0],
                      instr_i.s_fmt.imm_lo[4:1], 1'b0};

    assign imm_u_o = {instr_i.u_fmt.imm20, 12'h000};

    // J layout inside imm20 is imm[20|10:1|11|19:12].
    assign imm_j_o = {{12{sign}}, instr_i.u_fmt.imm20[7:0], instr_i.u_fmt.imm20[8],
                      instr_i.u_fmt.imm20[18:9], 1'b0};

endmodule

// File: design/rv_pkg.sv
package rv_pkg;

    localparam int XLEN = 32;
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
    localparam int RAM_WORDS = 256;
    localparam int RAM_AW = $clog2(RAM_WORDS);  // Word index width of the RAM.

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_e;

    localparam logic [2:0] F3_LB = 3'b000;
    localparam logic [2:0] F3_LH = 3'b001;
    localparam logic [2:0] F3_LW = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SR = 3'b101;
    localparam logic [2:0] F3_OR = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    localparam logic [6:0] F7_ALT = 7'b0100000;  // Selects SUB and SRA/SRAI.

    typedef enum logic [2:0] {
        S_FETCH     = 3'd0,
        S_REG_READ  = 3'd1,
        S_EXECUTE   = 3'd2,
        S_MEMORY    = 3'd3,
        S_REG_WRITE = 3'd4,
        S_RESET     = 3'd7
    } state_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;  // B format shares this layout.
        u_fmt_t u_fmt;  // J format shares this layout.
    } instr_u;

endpackage

// File: design/rv_program_counter.sv
`timescale 1ns/1ps

module rv_program_counter (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    count_i,
    input  logic                    load_i,
    input  logic [rv_pkg::XLEN-1:0] value_i,
    output logic [rv_pkg::XLEN-1:0] pc_o,
    output logic [rv_pkg::XLEN-1:0] pc_inc_o
);

    assign pc_inc_o = pc_o + rv_pkg::XLEN'(4);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_o <= rv_pkg::RESET_PC;
        end else if (load_i) begin
            pc_o <= value_i;  // Jumps and taken branches win over counting.
        end else if (count_i) begin
            pc_o <= pc_inc_o;
        end
    end

endmodule

// File: design/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic                    clk_i,
    input  logic                    we_i,
    input  logic [4:0]              waddr_i,
    input  logic [4:0]              raddr1_i,
    input  logic [4:0]              raddr2_i,
    input  logic [rv_pkg::XLEN-1:0] wdata_i,
    output logic [rv_pkg::XLEN-1:0] rdata1_o,
    output logic [rv_pkg::XLEN-1:0] rdata2_o
);

    logic [rv_pkg::XLEN-1:0] regs [31:1];  // x0 has no storage.

    always_ff @(posedge clk_i) begin
        if (we_i && (waddr_i != 5'd0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Reads see the old value on the cycle of a write to the same register.
    assign rdata1_o = (raddr1_i == 5'd0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == 5'd0) ? '0 : regs[raddr2_i];

endmodule

// File: design/rv_soc.sv
`timescale 1ns/1ps

module rv_soc (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    host_we_i,
    input  logic [rv_pkg::XLEN-1:0] host_adr_i,
    input  logic [rv_pkg::XLEN-1:0] host_dat_i,
    output logic                    retire_o,
    output logic [rv_pkg::XLEN-1:0] retire_pc_o,
    output logic [4:0]              retire_rd_o,
    output logic                    retire_we_o,
    output logic [rv_pkg::XLEN-1:0] retire_data_o
);

    wb_if bus0 ();

    rv_core u_core (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .bus           (bus0.master),
        .retire_o      (retire_o),
        .retire_we_o   (retire_we_o),
        .retire_pc_o   (retire_pc_o),
        .retire_data_o (retire_data_o),
        .retire_rd_o   (retire_rd_o)
    );

    wb_ram u_ram (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .bus        (bus0.slave),
        .host_we_i  (host_we_i),
        .host_adr_i (host_adr_i),
        .host_dat_i (host_dat_i)
    );

endmodule

// File: design/wb_if.sv
`timescale 1ns/1ps

interface wb_if;

    logic                     cyc;
    logic                     stb;
    logic                     we;
    logic [rv_pkg::XLEN-1:0]  adr;
    logic [3:0]               sel;
    logic [rv_pkg::XLEN-1:0]  dat_w;
    logic [rv_pkg::XLEN-1:0]  dat_r;
    logic                     ack;

    modport master (
        output cyc, stb, we, adr, sel, dat_w,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, sel, dat_w,
        output dat_r, ack
    );

endinterface

// File: design/wb_ram.sv
`timescale 1ns/1ps

module wb_ram (
    input  logic                    clk_i,
    input  logic                    rst_i,
    wb_if.slave                     bus,
    input  logic                    host_we_i,
    input  logic [rv_pkg::XLEN-1:0] host_adr_i,
    input  logic [rv_pkg::XLEN-1:0] host_dat_i
);

    logic [rv_pkg::XLEN-1:0]   mem [rv_pkg::RAM_WORDS];
    logic                      req;
    logic [rv_pkg::RAM_AW-1:0] bus_idx;
    logic [rv_pkg::RAM_AW-1:0] host_idx;

    assign req = bus.cyc && bus.stb && !bus.ack;  // New request not yet acknowledged.
    assign bus_idx = bus.adr[rv_pkg::RAM_AW+1:2];
    assign host_idx = host_adr_i[rv_pkg::RAM_AW+1:2];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= req;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            if (host_we_i) begin
                mem[host_idx] <= host_dat_i;  // Host loads only while the core is held.
            end
        end else if (req) begin
            bus.dat_r <= mem[bus_idx];
            if (bus.we) begin
                for (int i = 0; i < 4; i++) begin
                    if (bus.sel[i]) mem[bus_idx][8*i +: 8] <= bus.dat_w[8*i +: 8];
                end
            end
        end
    end

endmodule

// File: dv/rv_core_assertions.sv
`timescale 1ns/1ps

module rv_core_assertions (
    input logic                    clk_i,
    input logic                    rst_i,
    input logic                    cyc_i,
    input logic                    stb_i,
    input logic                    we_i,
    input logic                    ack_i,
    input logic [rv_pkg::XLEN-1:0] adr_i,
    input logic [3:0]              sel_i,
    input logic [rv_pkg::XLEN-1:0] dat_w_i,
    input rv_pkg::state_e          state_i,
    input logic                    retire_i
);

    a_stb_needs_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
        stb_i |-> cyc_i)
        else $error("Bus strobe is high without cycle.");

    a_request_held: assert property (@(posedge clk_i) disable iff (rst_i)
        stb_i && !ack_i |=> stb_i && $stable(adr_i) && $stable(we_i) && $stable(sel_i))
        else $error("Bus request changed before acknowledge.");

    a_write_data_held: assert property (@(posedge clk_i) disable iff (rst_i)
        stb_i && we_i && !ack_i |=> $stable(dat_w_i))
        else $error("Bus write data changed before acknowledge.");

    a_stb_drops: assert property (@(posedge clk_i) disable iff (rst_i)
        stb_i && ack_i |=> !stb_i)
        else $error("Bus strobe stayed high after acknowledge.");

    a_no_write_in_fetch: assert property (@(posedge clk_i) disable iff (rst_i)
        state_i == rv_pkg::S_FETCH |-> !we_i)
        else $error("Bus write enable is high during instruction fetch.");

    a_retire_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        retire_i |=> !retire_i)
        else $error("Retire lasted longer than one cycle.");

endmodule

bind rv_core rv_core_assertions u_core_assertions (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .cyc_i    (bus.cyc),
    .stb_i    (bus.stb),
    .we_i     (bus.we),
    .ack_i    (bus.ack),
    .adr_i    (bus.adr),
    .sel_i    (bus.sel),
    .dat_w_i  (bus.dat_w),
    .state_i  (state),
    .retire_i (retire_o)
);

// File: dv/rv_soc_tb.sv
`timescale 1ns/1ps

module rv_soc_tb;

    localparam int CLK_PERIOD = 40;
    localparam int STIM_DELAY = 2;
    localparam int RESET_CYCLES = 10;
    localparam int RETIRE_TIMEOUT = 50;  // Cycles allowed between two retires.
    localparam int MAX_ROWS = 64;

    logic        clk;
    logic        rst;
    logic        host_we;
    logic [31:0] host_adr;
    logic [31:0] host_dat;
    logic        retire;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd;
    logic        retire_we;
    logic [31:0] retire_data;

    logic [31:0] prog_word [MAX_ROWS];
    bit          exp_ret [MAX_ROWS];  // Row is skipped by a jump or branch when clear.
    bit          exp_we [MAX_ROWS];
    logic [4:0]  exp_rd [MAX_ROWS];
    logic [31:0] exp_data [MAX_ROWS];
    int          rows;
    int          errors;
    int          timeouts;

    rv_soc dut0 (
        .clk_i         (clk),
        .rst_i         (rst),
        .host_we_i     (host_we),
        .host_adr_i    (host_adr),
        .host_dat_i    (host_dat),
        .retire_o      (retire),
        .retire_pc_o   (retire_pc),
        .retire_rd_o   (retire_rd),
        .retire_we_o   (retire_we),
        .retire_data_o (retire_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] r_type(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                           logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'(rv_pkg::OPC_OP)};
    endfunction

    function automatic logic [31:0] i_type(logic [6:0] opc, logic [2:0] f3, logic [4:0] rd,
                                           logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                           logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'(rv_pkg::OPC_STORE)};
    endfunction

    function automatic logic [31:0] b_type(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                           logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'(rv_pkg::OPC_BRANCH)};
    endfunction

    function automatic logic [31:0] u_type(logic [6:0] opc, logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_type(logic [4:0] rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'(rv_pkg::OPC_JAL)};
    endfunction

    task automatic add_row(logic [31:0] word, bit ret, bit we, logic [4:0] rd,
                           logic [31:0] data);
        prog_word[rows] = word;
        exp_ret[rows] = ret;
        exp_we[rows] = we;
        exp_rd[rows] = rd;
        exp_data[rows] = data;
        rows++;
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("ERR %0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic wait_for_retire(output bit seen);
        int n;
        n = 0;
        seen = 0;
        while (!seen && n < RETIRE_TIMEOUT) begin
            @(negedge clk);  // Outputs are settled half a cycle after the edge.
            n++;
            if (retire === 1'b1) seen = 1;
        end
    endtask

    task automatic build_program();
        rows = 0;
        add_row(i_type(rv_pkg::OPC_OP_IMM, rv_pkg::F3_ADD, 1, 0, 12'd5), 1, 1, 1, 32'h5);
        add_row(i_type(rv_pkg::OPC_OP_IMM, rv_pkg::F3_ADD, 2, 0, 12'hffd), 1, 1, 2, 32'hfffffffd);
        add_row(r_type(7'd0, rv_pkg::F3_ADD, 3, 1, 2), 1, 1, 3, 32'h2);
        add_row(r_type(rv_pkg::F7_ALT, rv_pkg::F3_ADD, 4, 1, 2), 1, 1, 4, 32'h8);
        add_row(i_type(rv_pkg::OPC_OP_IMM, rv_pkg::F3_SLL, 5, 1, 12'd4), 1, 1, 5, 32'h50);
        add_row(i_type(rv_pkg::OPC_OP_IMM, rv_pkg::F3_SR, 6, 2, 12'h401), 1, 1, 6, 32'hfffffffe);
        add_row(i_type(rv_pkg::OPC_OP_IMM, rv_pkg::F3_SR, 7, 2, 12'd28), 1, 1, 7, 32'hf);
        add_row(r_type(7'd0, rv_pkg::F3_SLT, 8, 2, 1), 1, 1, 8, 32'h1);
        add_row(r_type(7'd0, rv_pkg::F3_SLTU, 9, 2, 1), 1, 1, 9, 32'h0);
        add_row(i_type(rv_pkg::OPC_OP_IMM, rv_pkg::F3_XOR, 10, 5, 12'hff), 1, 1, 10, 32'haf);
        add_row(r_type(7'd0, rv_pkg::F3_AND, 11, 10, 7), 1, 1, 11, 32'hf);
        add_row(r_type(7'd0, rv_pkg::F3_OR, 12, 5, 4), 1, 1, 12, 32'h58);
        add_row(i_type(rv_pkg::OPC_OP_IMM, rv_pkg::F3_ADD, 0, 1, 12'd7), 1, 1, 0, 32'hc);
        add_row(r_type(7'd0, rv_pkg::F3_ADD, 13, 0, 1), 1, 1, 13, 32'h5);  // x0 still zero.
        add_row(u_type(rv_pkg::OPC_LUI, 14, 20'h12345), 1, 1, 14, 32'h12345000);
        add_row(u_type(rv_pkg::OPC_AUIPC, 15, 20'h00001), 1, 1, 15, 32'h103c);
        add_row(j_type(16, 21'd12), 1, 1, 16, 32'h44);
        add_row(i_type(rv_pkg::OPC_OP_IMM, rv_pkg::F3_ADD, 20, 0, 12'd1), 0, 0, 0, 0);
        add_row(i_type(rv_pkg::OPC_OP_IMM, rv_pkg::F3_ADD, 20, 0, 12'd2), 0, 0, 0, 0);
        add_row(i_type(rv_pkg::OPC_JALR, 3'b000, 17, 13, 12'h054), 1, 1, 17, 32'h50);
        add_row(i_type(rv_pkg::OPC_OP_IMM, rv_pkg::F3_ADD, 20, 0, 12'd3), 0, 0, 0, 0);
        add_row(i_type(rv_pkg::OPC_OP_IMM, rv_pkg::F3_ADD, 20, 0, 12'd4), 0, 0, 0, 0);
        add_row(i_type(rv_pkg::OPC_OP_IMM, rv_pkg::F3_ADD, 18, 0, 12'h200), 1, 1, 18, 32'h200);
        add_row(s_type(rv_pkg::F3_SW, 18, 14, 12'd0), 1, 0, 0, 0);
        add_row(s_type(rv_pkg::F3_SH, 18, 2, 12'd2), 1, 0, 0, 0);
        add_row(s_type(rv_pkg::F3_SB, 18, 1, 12'd1), 1, 0, 0, 0);
        add_row(i_type(rv_pkg::OPC_LOAD, rv_pkg::F3_LW, 19, 18, 12'd0), 1, 1, 19, 32'hfffd0500);
        add_row(i_type(rv_pkg::OPC_LOAD, rv_pkg::F3_LH, 20, 18, 12'd2), 1, 1, 20, 32'hfffffffd);
        add_row(i_type(rv_pkg::OPC_LOAD, rv_pkg::F3_LHU, 21, 18, 12'd2), 1, 1, 21, 32'h0000fffd);
        add_row(i_type(rv_pkg::OPC_LOAD, rv_pkg::F3_LB, 22, 18, 12'd3), 1, 1, 22, 32'hffffffff);
        add_row(i_type(rv_pkg::OPC_LOAD, rv_pkg::F3_LBU, 23, 18, 12'd2), 1, 1, 23, 32'h000000fd);
        add_row(b_type(rv_pkg::F3_BEQ, 1, 13, 13'd8), 1, 0, 0, 0);
        add_row(i_type(rv_pkg::OPC_OP_IMM, rv_pkg::F3_ADD, 20, 0, 12'd5), 0, 0, 0, 0);
        add_row(b_type(rv_pkg::F3_BNE, 1, 13, 13'd8), 1, 0, 0, 0);  // Falls through.
        add_row(b_type(rv_pkg::F3_BLT, 2, 1, 13'd8), 1, 0, 0, 0);
        add_row(i_type(rv_pkg::OPC_OP_IMM, rv_pkg::F3_ADD, 20, 0, 12'd6), 0, 0, 0, 0);
        add_row(i_type(rv_pkg::OPC_OP_IMM, rv_pkg::F3_ADD, 24, 19, 12'd1), 1, 1, 24, 32'hfffd0501);
        add_row(j_type(0, 21'd0), 1, 1, 0, 32'h98);  // Parks the core in a loop.
    endtask

    always @(negedge clk) begin
        if (rst === 1'b1) begin
            assert (retire !== 1'b1) else begin
                errors++;
                $display("Retire was reported while reset was held at %0t.", $time);
            end
        end
    end

    initial begin
        int  i;
        bit  seen;
        clk = 1'b0;
        rst = 1'b1;
        host_we = 1'b0;
        host_adr = '0;
        host_dat = '0;
        errors = 0;
        timeouts = 0;
        build_program();
        for (i = 0; i < rows; i++) begin
            @(posedge clk);
            #(STIM_DELAY);
            host_we = 1'b1;
            host_adr = rv_pkg::RESET_PC + 32'(4 * i);
            host_dat = prog_word[i];
        end
        @(posedge clk);
        #(STIM_DELAY);
        host_we = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #(STIM_DELAY);
        rst = 1'b0;
        for (i = 0; i < rows && timeouts == 0; i++) begin
            if (exp_ret[i]) begin
                wait_for_retire(seen);
                if (!seen) begin
                    timeouts++;
                    $display("Timeout: no retire for table row %0d within %0d cycles.",
                             i, RETIRE_TIMEOUT);
                end else begin
                    check_value("retire_pc_o", rv_pkg::RESET_PC + 32'(4 * i), retire_pc);
                    check_value("retire_we_o", 32'(exp_we[i]), 32'(retire_we));
                    if (exp_we[i]) begin
                        check_value("retire_rd_o", 32'(exp_rd[i]), 32'(retire_rd));
                        check_value("retire_data_o", exp_data[i], retire_data);
                    end
                end
            end
        end
        $display("Summary: %0d value errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: sources.f
design/rv_pkg.sv
design/wb_if.sv
design/rv_program_counter.sv
design/rv_regfile.sv
design/rv_imm_decode.sv
design/rv_alu.sv
design/rv_core.sv
design/wb_ram.sv
design/rv_soc.sv
dv/rv_core_assertions.sv
dv/rv_soc_tb.sv
